// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rename_pkg.sv
      - hdl/map_table.sv
      - hdl/free_list.sv
      - hdl/told_buffer.sv
      - hdl/rename_stage.sv
      - target: test
        files:
          - verification/rename_tb.sv

// ==== compile.f ====
+incdir+hdl
hdl/rename_pkg.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/told_buffer.sv
hdl/rename_stage.sv
verification/rename_tb.sv

// ==== hdl/free_list.sv ====
`include "rename_config.svh"

module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_accept,
  input  rename_pkg::rob_idx_t  alloc_idx,
  input  logic                  release_en,
  input  rename_pkg::phys_tag_t release_tag,
  input  logic                  rollback_en,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output rename_pkg::phys_tag_t new_tag
);
  import rename_pkg::*;

  localparam int PTR_W = $clog2(`NUM_PR);

  // circular queue of free tags, one slot per physical tag
  phys_tag_t [`NUM_PR-1:0] tags;

  // pop side and push side
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] head_inc;
  logic [PTR_W-1:0] tail_inc;

  // head right after each slot took its tag
  logic [`NUM_ROB-1:0][PTR_W-1:0] head_ckpt;

  // queue depth is not a power of two, so wrap by hand
  function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] last;
    last = PTR_W'(`NUM_PR - 1);
    return (ptr == last) ? '0 : ptr + 1'b1;
  endfunction

  assign head_inc = wrap_inc(head);
  assign tail_inc = wrap_inc(tail);

  // tag handed to the current dispatch
  assign new_tag = tags[head];

  // pointers
  // rollback moves head back, so squashed tags get handed out again
  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= PTR_W'(`NUM_ROB);
    end else begin
      if (rollback_en) begin
        head <= head_ckpt[rollback_idx];
      end else if (dispatch_accept) begin
        head <= head_inc;
      end
      if (release_en) begin
        tail <= tail_inc;
      end
    end
  end

  // queue contents
  // first NUM_ROB entries start as the tags above the arch regs
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_PR; i++) begin
        tags[i] <= phys_tag_t'((i + `NUM_ARCH) % `NUM_PR);
      end
    end else if (release_en) begin
      tags[tail] <= release_tag;
    end
  end

  // saved head per slot is already past the popped tag
  always_ff @(posedge clock) begin
    if (dispatch_accept) begin
      head_ckpt[alloc_idx] <= head_inc;
    end
  end

endmodule

// ==== hdl/map_table.sv ====
`include "rename_config.svh"

module map_table (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch_accept,
  input  rename_pkg::dispatch_req_t dispatch_req,
  input  rename_pkg::phys_tag_t     new_tag,
  input  logic                      cdb_en,
  input  rename_pkg::cdb_t          cdb,
  input  logic                      rollback_en,
  input  rename_pkg::rob_idx_t      rollback_idx,
  input  rename_pkg::rob_idx_t      alloc_idx,
  output rename_pkg::operand_tags_t operands,
  output rename_pkg::phys_tag_t     told
);
  import rename_pkg::*;

  // live map and its next value
  map_entry_t [`NUM_ARCH-1:0] map_q;
  map_entry_t [`NUM_ARCH-1:0] map_next;

  // one backup copy of the map per reorder slot
  map_entry_t [`NUM_ROB-1:0][`NUM_ARCH-1:0] ckpt;
  map_entry_t [`NUM_ARCH-1:0]               ckpt_next;

  // raw source entries before the bypass
  map_entry_t src_a;
  map_entry_t src_b;

  // sources and told come from the map as it stands this cycle
  assign src_a = map_q[dispatch_req.rega];
  assign src_b = map_q[dispatch_req.regb];
  assign told  = map_q[dispatch_req.dest].tag;

  always_comb begin
    operands.t1.tag = src_a.tag;
    operands.t2.tag = src_b.tag;
    // cdb bypass
    // a tag on the cdb right now counts as ready
    // tags are unique, so a tag match alone is enough here
    operands.t1.ready = src_a.ready || (cdb_en && (cdb.tag == src_a.tag));
    operands.t2.ready = src_b.ready || (cdb_en && (cdb.tag == src_b.tag));
  end

  // next map
  // rollback first, cdb on top, dispatch write last
  always_comb begin
    map_next = map_q;
    if (rollback_en) begin
      map_next = ckpt[rollback_idx];
    end
    // only if dest still maps to this tag
    // otherwise the dest was renamed again and the broadcast is stale
    if (cdb_en && (map_q[cdb.dest].tag == cdb.tag)) begin
      map_next[cdb.dest].ready = 1'b1;
    end
    if (dispatch_accept) begin
      // new tag, result not produced yet
      map_next[dispatch_req.dest] = '{tag: new_tag, ready: 1'b0};
      // zero reg stays ready even when named as dest
      map_next[`ZERO_REG].ready = 1'b1;
    end
  end

  // checkpoint image
  // mapping after this dispatch with every entry marked ready
  always_comb begin
    ckpt_next = map_next;
    for (int i = 0; i < `NUM_ARCH; i++) begin
      ckpt_next[i].ready = 1'b1;
    end
  end

  // identity map out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_ARCH; i++) begin
        map_q[i] <= '{tag: phys_tag_t'(i), ready: 1'b1};
      end
    end else begin
      map_q <= map_next;
    end
  end

  // backup copies
  always_ff @(posedge clock) begin
    if (dispatch_accept) begin
      ckpt[alloc_idx] <= ckpt_next;
    end
  end

endmodule

// ==== hdl/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file size
`define NUM_ARCH 32

// reorder slots, also the depth of the told buffer
`define NUM_ROB 16

// physical tags
// one per arch reg plus one per in-flight instruction,
// so the free list never runs dry while the told buffer has room
`define NUM_PR (`NUM_ARCH + `NUM_ROB)

// hardwired zero register, always ready
`define ZERO_REG 31

`endif

// ==== hdl/rename_pkg.sv ====
`include "rename_config.svh"

package rename_pkg;

  // register and slot numbers
  typedef logic [$clog2(`NUM_ARCH)-1:0] arch_idx_t;
  typedef logic [$clog2(`NUM_PR)-1:0]   phys_tag_t;
  typedef logic [$clog2(`NUM_ROB)-1:0]  rob_idx_t;

  // one map table entry
  typedef struct packed {
    phys_tag_t tag;
    logic      ready;
  } map_entry_t;

  // decoded register fields of the dispatching instruction
  typedef struct packed {
    arch_idx_t dest;
    arch_idx_t rega;
    arch_idx_t regb;
  } dispatch_req_t;

  // source tags with ready bits, to the reservation station
  typedef struct packed {
    map_entry_t t1;
    map_entry_t t2;
  } operand_tags_t;

  // result broadcast
  typedef struct packed {
    phys_tag_t tag;
    arch_idx_t dest;
  } cdb_t;

  // old mapping and its slot, to the reorder buffer
  typedef struct packed {
    phys_tag_t told;
    rob_idx_t  rob_idx;
  } rob_told_t;

endpackage

// ==== hdl/rename_stage.sv ====
module rename_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch_en,
  input  rename_pkg::dispatch_req_t dispatch_req,
  input  logic                      cdb_en,
  input  rename_pkg::cdb_t          cdb,
  input  logic                      retire_en,
  input  logic                      rollback_en,
  input  rename_pkg::rob_idx_t      rollback_idx,
  output rename_pkg::operand_tags_t operands,
  output rename_pkg::rob_told_t     rob_told,
  output logic                      stall
);
  import rename_pkg::*;

  // dispatch handshake from the told buffer
  logic      dispatch_accept;
  rob_idx_t  alloc_idx;

  // tag flow between the blocks
  phys_tag_t new_tag;
  phys_tag_t told;
  logic      release_en;
  phys_tag_t release_tag;

  // to the reorder buffer
  assign rob_told = '{told: told, rob_idx: alloc_idx};

  // arch to phys map, ready bits, checkpoints
  map_table u_map_table (
    .clock           (clock),
    .reset           (reset),
    .dispatch_accept (dispatch_accept),
    .dispatch_req    (dispatch_req),
    .new_tag         (new_tag),
    .cdb_en          (cdb_en),
    .cdb             (cdb),
    .rollback_en     (rollback_en),
    .rollback_idx    (rollback_idx),
    .alloc_idx       (alloc_idx),
    .operands        (operands),
    .told            (told)
  );

  // pool of unmapped tags
  free_list u_free_list (
    .clock           (clock),
    .reset           (reset),
    .dispatch_accept (dispatch_accept),
    .alloc_idx       (alloc_idx),
    .release_en      (release_en),
    .release_tag     (release_tag),
    .rollback_en     (rollback_en),
    .rollback_idx    (rollback_idx),
    .new_tag         (new_tag)
  );

  // reorder buffer stand-in that owns stall
  told_buffer u_told_buffer (
    .clock           (clock),
    .reset           (reset),
    .dispatch_en     (dispatch_en),
    .told            (told),
    .retire_en       (retire_en),
    .rollback_en     (rollback_en),
    .rollback_idx    (rollback_idx),
    .dispatch_accept (dispatch_accept),
    .alloc_idx       (alloc_idx),
    .release_en      (release_en),
    .release_tag     (release_tag),
    .stall           (stall)
  );

endmodule

// ==== hdl/told_buffer.sv ====
`include "rename_config.svh"

module told_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_en,
  input  rename_pkg::phys_tag_t told,
  input  logic                  retire_en,
  input  logic                  rollback_en,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output logic                  dispatch_accept,
  output rename_pkg::rob_idx_t  alloc_idx,
  output logic                  release_en,
  output rename_pkg::phys_tag_t release_tag,
  output logic                  stall
);
  import rename_pkg::*;

  localparam int CNT_W = $clog2(`NUM_ROB) + 1;

  // told tags in program order
  phys_tag_t [`NUM_ROB-1:0] told_mem;

  // oldest entry, next free slot, occupancy
  rob_idx_t         head;
  rob_idx_t         tail;
  logic [CNT_W-1:0] count;

  // distance from head to the rollback slot, and what survives
  rob_idx_t         keep_dist;
  logic [CNT_W-1:0] keep_count;

  // full when every reorder slot is in flight
  assign stall = (count == CNT_W'(`NUM_ROB));

  // the one place where dispatch is gated by back-pressure
  assign dispatch_accept = dispatch_en && !stall;
  assign alloc_idx       = tail;

  // retire on empty does nothing; rollback wins over retire
  assign release_en  = retire_en && (count != '0) && !rollback_en;
  assign release_tag = told_mem[head];

  // slot k itself survives, hence the +1
  // gives 1..NUM_ROB, so a full buffer cut at its last slot stays full
  assign keep_dist  = rollback_idx - head;
  assign keep_count = {1'b0, keep_dist} + 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (rollback_en) begin
      // drop everything younger than slot k
      tail  <= rollback_idx + 1'b1;
      count <= keep_count;
    end else begin
      if (dispatch_accept) begin
        tail <= tail + 1'b1;
      end
      if (release_en) begin
        head <= head + 1'b1;
      end
      case ({dispatch_accept, release_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // payload, written at the allocated slot
  always_ff @(posedge clock) begin
    if (dispatch_accept && !rollback_en) begin
      told_mem[tail] <= told;
    end
  end

endmodule

// ==== verification/rename_tb.sv ====
`include "rename_config.svh"

module rename_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import rename_pkg::*;

  // table row operation flags from msb to lsb
  // dispatch cdb retire rollback
  localparam logic [3:0] op_read = 4'b0000;
  localparam logic [3:0] op_disp = 4'b1000;
  localparam logic [3:0] op_cdb  = 4'b0100;
  localparam logic [3:0] op_ret  = 4'b0010;
  localparam logic [3:0] op_rb   = 4'b0001;

  // one cycle of stimulus and what the outputs must show in it
  typedef struct packed {
    logic [3:0]    op;
    dispatch_req_t req;
    cdb_t          cdb;
    rob_idx_t      rb_idx;
    operand_tags_t exp_ops;
    rob_told_t     exp_told;
    logic          exp_stall;
  } row_t;

  logic          clock;
  logic          reset;
  logic          dispatch_en;
  dispatch_req_t dispatch_req;
  logic          cdb_en;
  cdb_t          cdb;
  logic          retire_en;
  logic          rollback_en;
  rob_idx_t      rollback_idx;
  operand_tags_t operands;
  rob_told_t     rob_told;
  logic          stall;

  row_t        rows[$];
  int          row_num;
  int unsigned cycle_count;
  int unsigned cycle_limit;

  rename_stage DUT (
    .clock        (clock),
    .reset        (reset),
    .dispatch_en  (dispatch_en),
    .dispatch_req (dispatch_req),
    .cdb_en       (cdb_en),
    .cdb          (cdb),
    .retire_en    (retire_en),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .operands     (operands),
    .rob_told     (rob_told),
    .stall        (stall)
  );

  // 4 ns period
  always #2 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // watchdog
  // limit is set once the table is known
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      fail_run($sformatf("timeout after %0d cycles, table not finished", cycle_count));
    end
  end

  task automatic check_operands(input operand_tags_t got, input operand_tags_t exp);
    if (got !== exp) begin
      fail_run($sformatf(
        "mismatch at %0t row %0d operands got t1=%0d/%b t2=%0d/%b expected t1=%0d/%b t2=%0d/%b",
        $time, row_num, got.t1.tag, got.t1.ready, got.t2.tag, got.t2.ready,
        exp.t1.tag, exp.t1.ready, exp.t2.tag, exp.t2.ready));
    end
  endtask

  task automatic check_told(input rob_told_t got, input rob_told_t exp);
    if (got !== exp) begin
      fail_run($sformatf(
        "mismatch at %0t row %0d rob_told got told=%0d idx=%0d expected told=%0d idx=%0d",
        $time, row_num, got.told, got.rob_idx, exp.told, exp.rob_idx));
    end
  endtask

  task automatic check_stall(input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t row %0d stall got %b expected %b",
        $time, row_num, got, exp));
    end
  endtask

  task automatic add_row(input logic [3:0] op, input int dest, input int rega, input int regb,
                         input int cdb_tag, input int cdb_dest, input int rb_idx,
                         input int t1_tag, input int t1_rdy, input int t2_tag, input int t2_rdy,
                         input int told, input int idx, input int stall_exp);
    row_t r;
    r.op                = op;
    r.req.dest          = arch_idx_t'(dest);
    r.req.rega          = arch_idx_t'(rega);
    r.req.regb          = arch_idx_t'(regb);
    r.cdb.tag           = phys_tag_t'(cdb_tag);
    r.cdb.dest          = arch_idx_t'(cdb_dest);
    r.rb_idx            = rob_idx_t'(rb_idx);
    r.exp_ops.t1.tag    = phys_tag_t'(t1_tag);
    r.exp_ops.t1.ready  = t1_rdy[0];
    r.exp_ops.t2.tag    = phys_tag_t'(t2_tag);
    r.exp_ops.t2.ready  = t2_rdy[0];
    r.exp_told.told     = phys_tag_t'(told);
    r.exp_told.rob_idx  = rob_idx_t'(idx);
    r.exp_stall         = stall_exp[0];
    rows.push_back(r);
  endtask

  // columns are op, dest, rega, regb, cdb tag, cdb dest, rollback slot,
  // t1 tag, t1 ready, t2 tag, t2 ready, told, rob slot, stall
  task automatic build_table();
    // identity map out of reset
    add_row(op_read, 5, 1, 2, 0, 0, 0, 1, 1, 2, 1, 5, 0, 0);
    add_row(op_read, `ZERO_REG, 30, `ZERO_REG, 0, 0, 0, 30, 1, 31, 1, 31, 0, 0);
    // new tags count up from 32 and slots from 0
    // told is the old mapping
    add_row(op_disp, 1, 2, 3, 0, 0, 0, 2, 1, 3, 1, 1, 0, 0);
    add_row(op_disp, 2, 1, 1, 0, 0, 0, 32, 0, 32, 0, 2, 1, 0);
    add_row(op_disp, `ZERO_REG, 2, `ZERO_REG, 0, 0, 0, 33, 0, 31, 1, 31, 2, 0);
    // zero reg renamed to 34 but still ready
    add_row(op_read, 3, `ZERO_REG, 1, 0, 0, 0, 34, 1, 32, 0, 3, 3, 0);
    // matching cdb is bypassed and then held
    add_row(op_cdb, 4, 1, 2, 32, 1, 0, 32, 1, 33, 0, 4, 3, 0);
    add_row(op_read, 4, 1, 2, 0, 0, 0, 32, 1, 33, 0, 4, 3, 0);
    // r2 renamed again, then a stale cdb for its old tag 33
    add_row(op_disp, 2, 2, 1, 0, 0, 0, 33, 0, 32, 1, 33, 3, 0);
    add_row(op_cdb, 5, 2, 3, 33, 2, 0, 35, 0, 3, 1, 5, 4, 0);
    add_row(op_read, 5, 2, 1, 0, 0, 0, 35, 0, 32, 1, 5, 4, 0);
    // fill the remaining slots 4..15 with tags 36..47
    for (int k = 0; k < `NUM_ROB - 4; k++) begin
      add_row(op_disp, 4 + k, 4 + k, 0, 0, 0, 0, 4 + k, 1, 0, 1, 4 + k, 4 + k, 0);
    end
    // buffer full so the dispatch is ignored
    add_row(op_disp, 20, 4, 15, 0, 0, 0, 36, 0, 47, 0, 20, 0, 1);
    add_row(op_read, 20, 20, 4, 0, 0, 0, 20, 1, 36, 0, 20, 0, 1);
    // retire frees told 1, then told 2
    add_row(op_ret, 20, 20, 4, 0, 0, 0, 20, 1, 36, 0, 20, 0, 1);
    add_row(op_ret, 20, 20, 4, 0, 0, 0, 20, 1, 36, 0, 20, 0, 0);
    // recycled tags come back in retire order
    add_row(op_disp, 20, 20, 1, 0, 0, 0, 20, 1, 32, 1, 20, 0, 0);
    add_row(op_disp, 21, 20, 21, 0, 0, 0, 1, 0, 21, 1, 21, 1, 0);
    add_row(op_read, 22, 21, 20, 0, 0, 0, 2, 0, 1, 0, 22, 2, 1);
    // rollback to slot 6
    // outputs still come from the old map this cycle
    add_row(op_rb, 7, 7, 4, 0, 0, 6, 39, 0, 36, 0, 39, 2, 1);
    // map of slot 6 with every entry ready and tail at 7
    add_row(op_read, 7, 7, 4, 0, 0, 0, 7, 1, 36, 1, 7, 7, 0);
    add_row(op_read, 20, 6, 2, 0, 0, 0, 38, 1, 35, 1, 20, 7, 0);
    // slot 7 gets 39 again as the first tag taken after slot 6
    add_row(op_disp, 8, 6, 20, 0, 0, 0, 38, 1, 20, 1, 8, 7, 0);
    add_row(op_read, 9, 8, 7, 0, 0, 0, 39, 0, 7, 1, 9, 8, 0);
  endtask

  task automatic drive_idle();
    dispatch_en  = 1'b0;
    dispatch_req = '0;
    cdb_en       = 1'b0;
    cdb          = '0;
    retire_en    = 1'b0;
    rollback_en  = 1'b0;
    rollback_idx = '0;
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    row_num      = 0;
    cycle_count  = 0;
    cycle_limit  = 0;
    drive_idle();
    build_table();
    cycle_limit = rows.size() * 2 + 20;

    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    foreach (rows[i]) begin
      @(negedge clock);
      row_num      = i;
      dispatch_en  = rows[i].op[3];
      dispatch_req = rows[i].req;
      cdb_en       = rows[i].op[2];
      cdb          = rows[i].cdb;
      retire_en    = rows[i].op[1];
      rollback_en  = rows[i].op[0];
      rollback_idx = rows[i].rb_idx;
      // combinational outputs settle well before the rising edge
      #1;
      check_operands(operands, rows[i].exp_ops);
      check_told(rob_told, rows[i].exp_told);
      check_stall(stall, rows[i].exp_stall);
    end

    @(negedge clock);
    drive_idle();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
